// ==== rtl/intr_cfg_pkg.sv ====
`default_nettype none

package intr_cfg_pkg;

    // ========================================
    // Interrupt vector sizing
    // ========================================

    // Number of interrupt vectors exercised by one test sequence
    localparam int NUM_INTR_IDS = 4;

    // Width of a vector ID
    localparam int INTR_ID_W = $clog2(NUM_INTR_IDS);

    // The response count must reach NUM_INTR_IDS, so it needs one extra bit
    localparam int INTR_CNT_W = INTR_ID_W + 1;

    // Only a single interrupt engine is built
    localparam int NUM_ENGINES = 1;

    // ========================================
    // Register map
    // ========================================

    localparam int CSR_IDX_W = 3;
    localparam int CSR_DATA_W = 64;

    // A write to index 0 is the start command
    localparam logic [CSR_IDX_W-1:0] CSR_TEST_ID_LO = 3'd0;
    localparam logic [CSR_IDX_W-1:0] CSR_TEST_ID_HI = 3'd1;
    localparam logic [CSR_IDX_W-1:0] CSR_CONFIG = 3'd2;
    localparam logic [CSR_IDX_W-1:0] CSR_RESULT = 3'd3;
    localparam logic [CSR_IDX_W-1:0] CSR_STATUS = 3'd4;

    // Identifier that software uses to recognize this test block
    localparam logic [127:0] TEST_ID = 128'h3c1e9a47_b2d0_4f86_a915_7e2c60d8b1f4;

endpackage

`default_nettype wire

// ==== rtl/intr_bus_pkg.sv ====
`default_nettype none

package intr_bus_pkg;

    // ========================================
    // Register access
    // ========================================

    // Register write, always accepted by the block
    typedef struct packed {
        logic [intr_cfg_pkg::CSR_IDX_W-1:0] idx;
        logic [intr_cfg_pkg::CSR_DATA_W-1:0] data;
    } csr_wr_t;

    // Register read request, data returns one cycle later
    typedef struct packed {
        logic [intr_cfg_pkg::CSR_IDX_W-1:0] idx;
    } csr_rd_t;

    // ========================================
    // Host interrupt channel
    // ========================================

    // Interrupt request toward the host
    // The interrupt flag is always set by the sequencer
    typedef struct packed {
        logic [intr_cfg_pkg::INTR_ID_W-1:0] id;
        logic intr;
    } intr_req_t;

    // Acknowledgement returned by the host
    // A well-formed response has intr set and fence clear
    typedef struct packed {
        logic [intr_cfg_pkg::INTR_ID_W-1:0] id;
        logic intr;
        logic fence;
    } intr_rsp_t;

    // Sequencer state
    typedef enum logic {
        SEQ_IDLE,
        SEQ_ISSUE
    } seq_state_t;

    // Classification of a single host response
    typedef enum logic [1:0] {
        RSP_OK,
        RSP_NO_INTR,
        RSP_FENCE
    } rsp_status_t;

endpackage

`default_nettype wire

// ==== rtl/intr_csr_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module intr_csr_regs
(
    input  wire logic clk,
    input  wire logic reset_n,

    // Register write port, always accepted
    input  wire logic csr_wr_valid,
    input  wire intr_bus_pkg::csr_wr_t csr_wr,

    // Register read port
    input  wire logic csr_rd_valid,
    input  wire intr_bus_pkg::csr_rd_t csr_rd,
    output logic csr_rd_data_valid,
    output logic [intr_cfg_pkg::CSR_DATA_W-1:0] csr_rd_data,

    // Start command toward the sequencer and the response tracker
    output logic start,
    output logic [intr_cfg_pkg::INTR_ID_W-1:0] start_count,

    // Status gathered from the engine
    input  wire logic active,
    input  wire logic [intr_cfg_pkg::INTR_CNT_W-1:0] rsp_count,
    input  wire logic [intr_cfg_pkg::NUM_INTR_IDS-1:0] rsp_mask,
    input  wire logic rsp_error
);

    // ========================================
    // Start command decode
    // ========================================

    // Any write to index 0 starts a sequence, whatever the engine is doing
    // The pulse lasts exactly as long as the write, which is one cycle
    assign start = csr_wr_valid && (csr_wr.idx == intr_cfg_pkg::CSR_TEST_ID_LO);

    // Only the low bits of the written value are meaningful as a vector ID
    // Larger counts wrap, so 6 starts from vector 2 with four vectors
    assign start_count = csr_wr.data[intr_cfg_pkg::INTR_ID_W-1:0];

    // ========================================
    // Read data path
    // ========================================

    logic [intr_cfg_pkg::CSR_DATA_W-1:0] rd_word;

    // Read word selection, registered below
    always_comb
    begin
        case (csr_rd.idx)
            intr_cfg_pkg::CSR_TEST_ID_LO:
            begin
                rd_word = intr_cfg_pkg::TEST_ID[63:0];
            end
            intr_cfg_pkg::CSR_TEST_ID_HI:
            begin
                rd_word = intr_cfg_pkg::TEST_ID[127:64];
            end
            intr_cfg_pkg::CSR_CONFIG:
            begin
                // Vector count in the second byte, engine count in the first
                rd_word = {48'd0,
                           8'(intr_cfg_pkg::NUM_INTR_IDS),
                           8'(intr_cfg_pkg::NUM_ENGINES)};
            end
            intr_cfg_pkg::CSR_RESULT:
            begin
                // Acknowledged-vector mask above the response count
                rd_word = {40'd0, 16'(rsp_mask), 8'(rsp_count)};
            end
            intr_cfg_pkg::CSR_STATUS:
            begin
                // Bit 0 shows a running sequence, bit 1 a malformed response
                rd_word = {62'd0, rsp_error, active};
            end
            default:
            begin
                // Unmapped indices read as zero
                rd_word = '0;
            end
        endcase
    end

    // The valid flag is control state and is cleared by reset
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            csr_rd_data_valid <= 1'b0;
        end
        else
        begin
            csr_rd_data_valid <= csr_rd_valid;
        end
    end

    // Data follows the read request by one cycle
    always_ff @(posedge clk)
    begin
        csr_rd_data <= rd_word;
    end

endmodule

`default_nettype wire

// ==== rtl/intr_seq_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module intr_seq_fsm
(
    input  wire logic clk,
    input  wire logic reset_n,

    // Start command from the register block
    input  wire logic start,

    // Host back-pressure on the request stream
    input  wire logic intr_req_ready,

    // Current vector and end-of-sequence flag from the ID counter
    input  wire logic [intr_cfg_pkg::INTR_ID_W-1:0] cur_id,
    input  wire logic last_id,

    // Counter controls
    output logic load,
    output logic dec,

    // Request stream toward the host
    output logic intr_req_valid,
    output intr_bus_pkg::intr_req_t intr_req,

    // Sequence in progress
    output logic active
);

    intr_bus_pkg::seq_state_t state;
    intr_bus_pkg::seq_state_t state_nxt;
    logic handshake;

    // A request is offered for the whole time the sequence is running
    assign intr_req_valid = (state == intr_bus_pkg::SEQ_ISSUE);
    assign active = (state == intr_bus_pkg::SEQ_ISSUE);

    // Request transfers when the host is also ready
    assign handshake = intr_req_valid && intr_req_ready;

    // The ID comes straight from the counter, so it holds while stalled
    always_comb
    begin
        intr_req = '0;
        intr_req.id = cur_id;
        intr_req.intr = 1'b1;
    end

    // ========================================
    // Next-state logic
    // ========================================

    always_comb
    begin
        state_nxt = state;
        load = 1'b0;
        dec = 1'b0;

        case (state)
            intr_bus_pkg::SEQ_IDLE:
            begin
                if (start)
                begin
                    load = 1'b1;
                    state_nxt = intr_bus_pkg::SEQ_ISSUE;
                end
            end
            intr_bus_pkg::SEQ_ISSUE:
            begin
                // A new start wins over a handshake in the same cycle
                if (start)
                begin
                    load = 1'b1;
                end
                else if (handshake)
                begin
                    if (last_id)
                    begin
                        state_nxt = intr_bus_pkg::SEQ_IDLE;
                    end
                    else
                    begin
                        dec = 1'b1;
                    end
                end
            end
            default:
            begin
                state_nxt = intr_bus_pkg::SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= intr_bus_pkg::SEQ_IDLE;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    // A stalled request must not change until the host takes it
    // Only a restart from software may replace it
    assert property (@(posedge clk) disable iff (!reset_n)
        intr_req_valid && !intr_req_ready && !start
        |=> intr_req_valid && $stable(intr_req.id));

endmodule

`default_nettype wire

// ==== rtl/intr_id_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module intr_id_counter
(
    input  wire logic clk,
    input  wire logic reset_n,

    // Load the starting vector, takes priority over dec
    input  wire logic load,
    input  wire logic [intr_cfg_pkg::INTR_ID_W-1:0] load_value,

    // Step to the next lower vector
    input  wire logic dec,

    output logic [intr_cfg_pkg::INTR_ID_W-1:0] cur_id,
    output logic last_id
);

    // Vector 0 is always the final request of a sequence
    assign last_id = (cur_id == '0);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            cur_id <= '0;
        end
        else if (load)
        begin
            cur_id <= load_value;
        end
        else if (dec)
        begin
            cur_id <= cur_id - 1'b1;
        end
    end

    // The sequencer must stop at vector 0 instead of wrapping around
    assert property (@(posedge clk) disable iff (!reset_n)
        dec |-> !last_id);

endmodule

`default_nettype wire

// ==== rtl/intr_rsp_tracker.sv ====
`timescale 1ns/100ps
`default_nettype none

module intr_rsp_tracker
(
    input  wire logic clk,
    input  wire logic reset_n,

    // Start command clears the previous results
    input  wire logic start,

    // Response stream from the host, always accepted
    input  wire logic intr_rsp_valid,
    input  wire intr_bus_pkg::intr_rsp_t intr_rsp,

    // Results for the register block
    output logic [intr_cfg_pkg::INTR_CNT_W-1:0] rsp_count,
    output logic [intr_cfg_pkg::NUM_INTR_IDS-1:0] rsp_mask,
    output logic rsp_error
);

    intr_bus_pkg::rsp_status_t rsp_status;

    // ========================================
    // Response classification
    // ========================================

    // A missing interrupt flag is reported ahead of a stray fence
    always_comb
    begin
        if (!intr_rsp.intr)
        begin
            rsp_status = intr_bus_pkg::RSP_NO_INTR;
        end
        else if (intr_rsp.fence)
        begin
            rsp_status = intr_bus_pkg::RSP_FENCE;
        end
        else
        begin
            rsp_status = intr_bus_pkg::RSP_OK;
        end
    end

    // ========================================
    // Result accumulation
    // ========================================

    always_ff @(posedge clk)
    begin
        if (!reset_n || start)
        begin
            // A restart discards responses still arriving in the same cycle
            rsp_count <= '0;
            rsp_mask <= '0;
            rsp_error <= 1'b0;
        end
        else if (intr_rsp_valid)
        begin
            if (rsp_status == intr_bus_pkg::RSP_OK)
            begin
                rsp_count <= rsp_count + 1'b1;
                rsp_mask[intr_rsp.id] <= 1'b1;
            end
            else
            begin
                // Error stays set until the next start or reset
                // A bad response is not counted
                rsp_error <= 1'b1;
            end
        end
    end

    // The host may only acknowledge vectors that this block requested
    // This matters once the vector count is not a power of two
    assert property (@(posedge clk) disable iff (!reset_n)
        intr_rsp_valid |-> (intr_rsp.id < intr_cfg_pkg::NUM_INTR_IDS));

endmodule

`default_nettype wire

// ==== rtl/intr_test_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module intr_test_top
(
    input  wire logic clk,
    input  wire logic reset_n,

    // Register access from software
    input  wire logic csr_wr_valid,
    input  wire intr_bus_pkg::csr_wr_t csr_wr,
    input  wire logic csr_rd_valid,
    input  wire intr_bus_pkg::csr_rd_t csr_rd,
    output logic csr_rd_data_valid,
    output logic [intr_cfg_pkg::CSR_DATA_W-1:0] csr_rd_data,

    // Interrupt requests toward the host
    output logic intr_req_valid,
    output intr_bus_pkg::intr_req_t intr_req,
    input  wire logic intr_req_ready,

    // Acknowledgements from the host
    input  wire logic intr_rsp_valid,
    input  wire intr_bus_pkg::intr_rsp_t intr_rsp
);

    // Start command and its starting vector
    logic start;
    logic [intr_cfg_pkg::INTR_ID_W-1:0] start_count;

    // Sequencer to counter
    logic load;
    logic dec;
    logic [intr_cfg_pkg::INTR_ID_W-1:0] cur_id;
    logic last_id;

    // Status back to the registers
    logic active;
    logic [intr_cfg_pkg::INTR_CNT_W-1:0] rsp_count;
    logic [intr_cfg_pkg::NUM_INTR_IDS-1:0] rsp_mask;
    logic rsp_error;

    // ========================================
    // Register block
    // ========================================

    intr_csr_regs u_csr_regs
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .csr_wr_valid      (csr_wr_valid),
        .csr_wr            (csr_wr),
        .csr_rd_valid      (csr_rd_valid),
        .csr_rd            (csr_rd),
        .csr_rd_data_valid (csr_rd_data_valid),
        .csr_rd_data       (csr_rd_data),
        .start             (start),
        .start_count       (start_count),
        .active            (active),
        .rsp_count         (rsp_count),
        .rsp_mask          (rsp_mask),
        .rsp_error         (rsp_error)
    );

    // ========================================
    // Interrupt engine
    // ========================================

    intr_seq_fsm u_seq_fsm
    (
        .clk            (clk),
        .reset_n        (reset_n),
        .start          (start),
        .intr_req_ready (intr_req_ready),
        .cur_id         (cur_id),
        .last_id        (last_id),
        .load           (load),
        .dec            (dec),
        .intr_req_valid (intr_req_valid),
        .intr_req       (intr_req),
        .active         (active)
    );

    intr_id_counter u_id_counter
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .load       (load),
        .load_value (start_count),
        .dec        (dec),
        .cur_id     (cur_id),
        .last_id    (last_id)
    );

    intr_rsp_tracker u_rsp_tracker
    (
        .clk            (clk),
        .reset_n        (reset_n),
        .start          (start),
        .intr_rsp_valid (intr_rsp_valid),
        .intr_rsp       (intr_rsp),
        .rsp_count      (rsp_count),
        .rsp_mask       (rsp_mask),
        .rsp_error      (rsp_error)
    );

endmodule

`default_nettype wire

// ==== dv/tb_intr_test.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_intr_test;

    // Upper bound in clock cycles for every wait loop
    localparam int WAIT_LIMIT = 200;

    // Ready behavior of the host model
    localparam int READY_ALWAYS = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_BUDGET = 2;

    // Kinds of malformed response that a test can inject
    localparam int BAD_NONE = 0;
    localparam int BAD_FENCE = 1;
    localparam int BAD_NO_INTR = 2;

    logic clk;
    logic reset_n;
    logic csr_wr_valid;
    intr_bus_pkg::csr_wr_t csr_wr;
    logic csr_rd_valid;
    intr_bus_pkg::csr_rd_t csr_rd;
    logic csr_rd_data_valid;
    logic [intr_cfg_pkg::CSR_DATA_W-1:0] csr_rd_data;
    logic intr_req_valid;
    intr_bus_pkg::intr_req_t intr_req;
    logic intr_req_ready;
    logic intr_rsp_valid;
    intr_bus_pkg::intr_rsp_t intr_rsp;

    // Host model state, only changed on the falling edge
    integer seed;
    integer rnd;
    int ready_mode;
    int ready_budget;
    int bad_kind;
    int rsp_gap;
    int rsp_q[$];

    // Scoreboard state, only changed on the rising edge
    int exp_ids[$];
    int accept_cycs[$];
    int exp_id;
    int cyc;
    int outstanding;
    int bad_seen;

    // Report counters
    int error_count;
    int errors_before_test;
    int tests_run;
    int tests_failed;

    intr_test_top u_dut
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .csr_wr_valid      (csr_wr_valid),
        .csr_wr            (csr_wr),
        .csr_rd_valid      (csr_rd_valid),
        .csr_rd            (csr_rd),
        .csr_rd_data_valid (csr_rd_data_valid),
        .csr_rd_data       (csr_rd_data),
        .intr_req_valid    (intr_req_valid),
        .intr_req          (intr_req),
        .intr_req_ready    (intr_req_ready),
        .intr_rsp_valid    (intr_rsp_valid),
        .intr_rsp          (intr_rsp)
    );

    // 100 ns clock period
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    // ========================================
    // Checks and reference model
    // ========================================

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else
        begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond)
        else
        begin
            $display("Error: %s", what);
            error_count++;
        end
    endtask

    // Expected ID order and result word for a start with count n
    // Only the vectors in acked are assumed to have been acknowledged
    function automatic void reference_model(
        input int n,
        input logic [intr_cfg_pkg::NUM_INTR_IDS-1:0] acked,
        output int ids[$],
        output logic [63:0] result_word
    );
        int first_id;
        int count;
        logic [intr_cfg_pkg::NUM_INTR_IDS-1:0] mask;
        // The vector count is a power of two, so the modulo is a truncation
        first_id = n % intr_cfg_pkg::NUM_INTR_IDS;
        count = 0;
        mask = '0;
        ids.delete();
        for (int id = first_id; id >= 0; id--)
        begin
            ids.push_back(id);
            if (acked[id])
            begin
                mask[id] = 1'b1;
                count++;
            end
        end
        // Mask sits above the count byte of the result register
        result_word = (64'(mask) << 8) | 64'(count);
    endfunction

    // ========================================
    // Host model and request monitor
    // ========================================

    // The host sees a stable valid and ID on the falling edge
    always @(negedge clk)
    begin
        intr_rsp_valid = 1'b0;
        intr_rsp = '0;
        case (ready_mode)
            READY_ALWAYS:
            begin
                intr_req_ready = 1'b1;
            end
            READY_RANDOM:
            begin
                rnd = $random(seed);
                intr_req_ready = rnd[0];
            end
            default:
            begin
                // Ready only for a limited number of transfers
                intr_req_ready = (ready_budget > 0);
                if (intr_req_ready && intr_req_valid)
                begin
                    ready_budget--;
                end
            end
        endcase
        if (rsp_q.size() != 0)
        begin
            // Acknowledge in request order after a random gap of 0 to 3 cycles
            if (rsp_gap == 0)
            begin
                intr_rsp_valid = 1'b1;
                intr_rsp.id = rsp_q.pop_front();
                intr_rsp.intr = 1'b1;
                intr_rsp.fence = 1'b0;
                rnd = $random(seed);
                rsp_gap = rnd[1:0];
            end
            else
            begin
                rsp_gap--;
            end
        end
        else if (bad_kind != BAD_NONE)
        begin
            intr_rsp_valid = 1'b1;
            intr_rsp.id = '0;
            intr_rsp.intr = (bad_kind != BAD_NO_INTR);
            intr_rsp.fence = (bad_kind == BAD_FENCE);
            bad_kind = BAD_NONE;
        end
    end

    // Compares every transferred request with the expected ID list
    always @(posedge clk)
    begin
        cyc++;
        if (intr_req_valid && intr_req_ready)
        begin
            accept_cycs.push_back(cyc);
            rsp_q.push_back(intr_req.id);
            outstanding++;
            check_value("intr_req.intr", 64'(intr_req.intr), 64'd1);
            if (exp_ids.size() == 0)
            begin
                check_true(1'b0, $sformatf("request with ID %0d was not expected",
                                           intr_req.id));
            end
            else
            begin
                exp_id = exp_ids.pop_front();
                check_value("intr_req.id", 64'(intr_req.id), 64'(exp_id));
            end
        end
        if (intr_rsp_valid)
        begin
            if (intr_rsp.intr && !intr_rsp.fence)
            begin
                outstanding--;
            end
            else
            begin
                bad_seen++;
            end
        end
    end

    // ========================================
    // Stimulus tasks
    // ========================================

    // Changed on the rising edge so the host picks it up cleanly
    task automatic set_ready(input int mode, input int budget);
        @(posedge clk);
        ready_mode = mode;
        ready_budget = budget;
    endtask

    // Returns the cycle number of the edge that took the write
    task automatic write_csr(input logic [intr_cfg_pkg::CSR_IDX_W-1:0] idx,
                             input logic [63:0] data, output int start_cyc);
        @(negedge clk);
        csr_wr_valid = 1'b1;
        csr_wr.idx = idx;
        csr_wr.data = data;
        @(negedge clk);
        csr_wr_valid = 1'b0;
        start_cyc = cyc;
    endtask

    // Read data must arrive exactly one cycle after the request
    // No read was issued in the cycle before, so valid is low at first
    task automatic expect_csr(input logic [intr_cfg_pkg::CSR_IDX_W-1:0] idx,
                              input logic [63:0] exp, input string name);
        @(negedge clk);
        check_true(!csr_rd_data_valid,
                   "read data valid was high with no read in the cycle before");
        csr_rd_valid = 1'b1;
        csr_rd.idx = idx;
        @(negedge clk);
        csr_rd_valid = 1'b0;
        check_true(csr_rd_data_valid, "read data did not come back one cycle after the read");
        check_value(name, csr_rd_data, exp);
    endtask

    task automatic wait_requests(input int left);
        int t;
        t = 0;
        while (exp_ids.size() > left && t < WAIT_LIMIT)
        begin
            @(negedge clk);
            t++;
        end
        check_true(exp_ids.size() <= left, "timeout waiting for interrupt requests");
    endtask

    task automatic wait_responses_done();
        int t;
        t = 0;
        while (outstanding != 0 && t < WAIT_LIMIT)
        begin
            @(negedge clk);
            t++;
        end
        check_true(outstanding == 0, "timeout waiting for host responses to drain");
    endtask

    task automatic inject_bad(input int kind);
        int seen_before;
        int t;
        seen_before = bad_seen;
        t = 0;
        @(posedge clk);
        bad_kind = kind;
        while (bad_seen == seen_before && t < WAIT_LIMIT)
        begin
            @(negedge clk);
            t++;
        end
        check_true(bad_seen != seen_before, "timeout waiting for the malformed response");
    endtask

    // Full sequence with every vector acknowledged, then result and status
    task automatic run_sequence(input int n, input int mode, input bit check_timing);
        int start_cyc;
        logic [63:0] result_word;
        set_ready(mode, 0);
        accept_cycs.delete();
        reference_model(n, '1, exp_ids, result_word);
        write_csr(intr_cfg_pkg::CSR_TEST_ID_LO, 64'(n), start_cyc);
        wait_requests(0);
        check_value("intr_req_valid", 64'(intr_req_valid), 64'd0);
        if (check_timing && accept_cycs.size() != 0)
        begin
            check_value("intr_req_valid first cycle", 64'(accept_cycs[0]),
                        64'(start_cyc + 1));
            for (int i = 1; i < accept_cycs.size(); i++)
            begin
                check_value("intr_req_valid cycle", 64'(accept_cycs[i]),
                            64'(accept_cycs[i-1] + 1));
            end
        end
        wait_responses_done();
        expect_csr(intr_cfg_pkg::CSR_RESULT, result_word, "csr_rd_data result");
        expect_csr(intr_cfg_pkg::CSR_STATUS, 64'd0, "csr_rd_data status");
    endtask

    task automatic test_end(input string name);
        tests_run++;
        if (error_count == errors_before_test)
        begin
            $display("Test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("Test %s: %0d errors", name, error_count - errors_before_test);
        end
        errors_before_test = error_count;
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial
    begin
        int scratch_ids[$];
        int start_cyc;
        logic [63:0] word;
        seed = 32'h551e_f0d5;
        reset_n = 1'b0;
        csr_wr_valid = 1'b0;
        csr_wr = '0;
        csr_rd_valid = 1'b0;
        csr_rd = '0;
        intr_req_ready = 1'b0;
        intr_rsp_valid = 1'b0;
        intr_rsp = '0;
        ready_mode = READY_ALWAYS;
        bad_kind = BAD_NONE;
        // Five rising edges see reset low, release follows on a falling edge
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // Identifier and configuration straight after reset
        expect_csr(intr_cfg_pkg::CSR_TEST_ID_LO, intr_cfg_pkg::TEST_ID[63:0], "csr_rd_data id_lo");
        expect_csr(intr_cfg_pkg::CSR_TEST_ID_HI, intr_cfg_pkg::TEST_ID[127:64],
                   "csr_rd_data id_hi");
        expect_csr(intr_cfg_pkg::CSR_CONFIG, {48'd0, 8'(intr_cfg_pkg::NUM_INTR_IDS), 8'd1},
                   "csr_rd_data config");
        expect_csr(intr_cfg_pkg::CSR_RESULT, 64'd0, "csr_rd_data result");
        expect_csr(intr_cfg_pkg::CSR_STATUS, 64'd0, "csr_rd_data status");
        test_end("1 reset values");

        run_sequence(3, READY_ALWAYS, 1'b1);
        test_end("2 back-to-back requests");

        // Count 6 wraps to a first vector of 2
        run_sequence(0, READY_ALWAYS, 1'b0);
        run_sequence(1, READY_ALWAYS, 1'b0);
        run_sequence(3, READY_ALWAYS, 1'b0);
        run_sequence(6, READY_ALWAYS, 1'b0);
        test_end("3 result count and mask");

        run_sequence(3, READY_RANDOM, 1'b0);
        run_sequence(6, READY_RANDOM, 1'b0);
        run_sequence(1, READY_RANDOM, 1'b0);
        test_end("4 random back-pressure");

        // Let two requests through, then stall the third
        set_ready(READY_BUDGET, 2);
        reference_model(3, '1, exp_ids, word);
        write_csr(intr_cfg_pkg::CSR_TEST_ID_LO, 64'd3, start_cyc);
        wait_requests(2);
        wait_responses_done();
        reference_model(3, 4'b1100, scratch_ids, word);
        expect_csr(intr_cfg_pkg::CSR_RESULT, word, "csr_rd_data result");
        // Restart while the host still holds ready low
        reference_model(2, '1, exp_ids, word);
        write_csr(intr_cfg_pkg::CSR_TEST_ID_LO, 64'd2, start_cyc);
        expect_csr(intr_cfg_pkg::CSR_RESULT, 64'd0, "csr_rd_data result");
        expect_csr(intr_cfg_pkg::CSR_STATUS, 64'd1, "csr_rd_data status");
        set_ready(READY_RANDOM, 0);
        wait_requests(0);
        wait_responses_done();
        expect_csr(intr_cfg_pkg::CSR_RESULT, word, "csr_rd_data result");
        test_end("5 restart mid-sequence");

        // Bad responses set the error bit and leave the result alone
        run_sequence(1, READY_ALWAYS, 1'b0);
        reference_model(1, '1, scratch_ids, word);
        inject_bad(BAD_FENCE);
        expect_csr(intr_cfg_pkg::CSR_RESULT, word, "csr_rd_data result");
        expect_csr(intr_cfg_pkg::CSR_STATUS, 64'd2, "csr_rd_data status");
        run_sequence(0, READY_RANDOM, 1'b0);
        reference_model(0, '1, scratch_ids, word);
        inject_bad(BAD_NO_INTR);
        expect_csr(intr_cfg_pkg::CSR_RESULT, word, "csr_rd_data result");
        expect_csr(intr_cfg_pkg::CSR_STATUS, 64'd2, "csr_rd_data status");
        run_sequence(2, READY_RANDOM, 1'b0);
        test_end("6 malformed responses");

        $display("Tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/intr_cfg_pkg.sv
rtl/intr_bus_pkg.sv
rtl/intr_csr_regs.sv
rtl/intr_seq_fsm.sv
rtl/intr_id_counter.sv
rtl/intr_rsp_tracker.sv
rtl/intr_test_top.sv
dv/tb_intr_test.sv
